/* logic/nb_fetch_consts.svh */
// neighborhood fetch constants

`ifndef NB_FETCH_CONSTS_SVH
`define NB_FETCH_CONSTS_SVH

// tile grid size, one grid only
`define NB_TILES_X 16
`define NB_TILES_Y 12

// coordinate widths, row and column
`define NB_I_W 4
`define NB_J_W 4

// 3x3 neighborhood and its token index
`define NB_COUNT 9
`define NB_IDX_W 4

// request tag is {group, token index}
`define NB_TAG_W 16
`define NB_GROUP_W (`NB_TAG_W - `NB_IDX_W)
`define NB_DATA_W 16

`endif

/* logic/nb_fetch_pkg.sv */
// neighborhood fetch types

`include "nb_fetch_consts.svh"

package nb_fetch_pkg;

  // --------------------------------------------------
  // state types
  // --------------------------------------------------

  // scheduler, waiting for a bundle or issuing reads
  typedef enum logic [0:0] {
    SCHED_IDLE  = 1'b0,
    SCHED_ISSUE = 1'b1
  } sched_state_e;

  // gather, filling slots or holding the full neighborhood
  typedef enum logic [0:0] {
    GATHER_COLLECT = 1'b0,
    GATHER_PRESENT = 1'b1
  } gather_state_e;

  // --------------------------------------------------
  // coordinate and data types
  // --------------------------------------------------
  typedef logic [`NB_I_W-1:0] tile_i_t;
  typedef logic [`NB_J_W-1:0] tile_j_t;

  // slot k holds the word of token k
  typedef logic [`NB_COUNT-1:0][`NB_DATA_W-1:0] nb_data_t;

endpackage

/* logic/rd_req_if.sv */
// sram read request channel

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

interface rd_req_if
  import nb_fetch_pkg::*;
();

  // handshake
  logic                 valid;
  logic                 ready;

  // payload, coordinates plus packed tag
  tile_i_t              tile_i;
  tile_j_t              tile_j;
  logic [`NB_TAG_W-1:0] tag;

  // scheduler side, split between fsm and coordinate buffer
  modport sched (
    output valid,
    output tile_i,
    output tile_j,
    output tag,
    input  ready
  );

  // memory side
  modport mem (
    input  valid,
    input  tile_i,
    input  tile_j,
    input  tag,
    output ready
  );

endinterface

/* logic/nb_coord_buffer.sv */
// neighbor coordinate buffer

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_coord_buffer
  import nb_fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load_i,
  input  tile_i_t              center_i_i,
  input  tile_j_t              center_j_i,
  input  logic [`NB_IDX_W-1:0] idx_i,
  rd_req_if.sched              rd
);

  // one row and one column per token
  tile_i_t              ci_q [`NB_COUNT];
  tile_j_t              cj_q [`NB_COUNT];
  logic [`NB_IDX_W-1:0] sel;

  // step 0 is minus one, 1 stays, 2 is plus one, held inside the grid
  function automatic tile_i_t clamp_i(tile_i_t c, int unsigned step);
    if (step == 0) return (c == '0) ? c : c - 1'b1;
    if (step == 2) return (c == tile_i_t'(`NB_TILES_Y - 1)) ? c : c + 1'b1;
    return c;
  endfunction

  function automatic tile_j_t clamp_j(tile_j_t c, int unsigned step);
    if (step == 0) return (c == '0) ? c : c - 1'b1;
    if (step == 2) return (c == tile_j_t'(`NB_TILES_X - 1)) ? c : c + 1'b1;
    return c;
  endfunction

  // --------------------------------------------------
  // latch all nine on bundle accept
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `NB_COUNT; k++) begin
        ci_q[k] <= '0;
        cj_q[k] <= '0;
      end
    end else if (load_i) begin
      // token k: row offset k/3 - 1, column offset k%3 - 1
      for (int k = 0; k < `NB_COUNT; k++) begin
        ci_q[k] <= clamp_i(center_i_i, k / 3);
        cj_q[k] <= clamp_j(center_j_i, k % 3);
      end
    end
  end

  // index past the last token falls back to token 8
  assign sel = (idx_i > `NB_IDX_W'(`NB_COUNT - 1)) ? `NB_IDX_W'(`NB_COUNT - 1) : idx_i;

  // coordinate of the current request
  assign rd.tile_i = ci_q[sel];
  assign rd.tile_j = cj_q[sel];

endmodule

/* logic/nb_token_counter.sv */
// token index counter

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_token_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear_i,
  input  logic                 adv_i,
  output logic [`NB_IDX_W-1:0] idx_o,
  output logic                 last_o
);

  localparam int unsigned IDX_W = `NB_IDX_W;

  // index of the final token in a bundle
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`NB_COUNT - 1);

  logic [IDX_W-1:0] idx_q;

  // --------------------------------------------------
  // count 0..8
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
    end else if (clear_i) begin
      // new bundle starts at token 0
      idx_q <= '0;
    end else if (adv_i) begin
      // wrap after the last token
      idx_q <= (idx_q == LAST_IDX) ? '0 : idx_q + 1'b1;
    end
  end

  assign idx_o  = idx_q;
  assign last_o = (idx_q == LAST_IDX);

endmodule

/* logic/nb_fetch_fsm.sv */
// read request scheduler

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_fetch_fsm
  import nb_fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en_i,
  input  logic                 nb_valid_i,
  output logic                 nb_ready_o,
  input  logic [`NB_GROUP_W-1:0] nb_group_i,
  rd_req_if.sched              rd,
  input  logic [`NB_IDX_W-1:0] idx_i,
  input  logic                 last_i,
  output logic                 cnt_clear_o,
  output logic                 cnt_adv_o,
  output logic                 load_o,
  output logic                 busy_o,
  output logic                 done_o
);

  sched_state_e            state_q;
  logic [`NB_GROUP_W-1:0]  group_q;
  logic                    req_fire;
  logic                    last_fire;
  logic                    nb_fire;

  // --------------------------------------------------
  // handshakes, all gated by enable
  // --------------------------------------------------
  assign rd.valid  = en_i && (state_q == SCHED_ISSUE);
  assign req_fire  = rd.valid && rd.ready;
  assign last_fire = req_fire && last_i;

  // next bundle may overlap the ninth request
  assign nb_ready_o = en_i && ((state_q == SCHED_IDLE) || last_fire);
  assign nb_fire    = nb_valid_i && nb_ready_o;

  // group in the upper bits, token in the low nibble
  assign rd.tag = {group_q, idx_i};

  // counter and coordinate buffer steering
  assign load_o      = nb_fire;
  assign cnt_clear_o = nb_fire;
  assign cnt_adv_o   = req_fire;

  assign busy_o = en_i && (state_q == SCHED_ISSUE);
  assign done_o = last_fire;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SCHED_IDLE;
    end else begin
      case (state_q)
        SCHED_IDLE: if (nb_fire) state_q <= SCHED_ISSUE;
        // stay in issue when a new bundle lands on the last request
        SCHED_ISSUE: if (last_fire && !nb_fire) state_q <= SCHED_IDLE;
        default: state_q <= SCHED_IDLE;
      endcase
    end
  end

  // group tag of the bundle in flight
  always_ff @(posedge clk) begin
    if (nb_fire) group_q <= nb_group_i;
  end

endmodule

/* logic/tile_sram.sv */
// tile data memory

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module tile_sram
  import nb_fetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  rd_req_if.mem                 rd,
  input  logic                  wr_en_i,
  input  tile_i_t               wr_i_i,
  input  tile_j_t               wr_j_i,
  input  logic [`NB_DATA_W-1:0] wr_data_i,
  output logic                  rsp_valid_o,
  output logic [`NB_TAG_W-1:0]  rsp_tag_o,
  output logic [`NB_DATA_W-1:0] rsp_data_o,
  input  logic                  rsp_ready_i
);

  localparam int unsigned DEPTH  = `NB_TILES_X * `NB_TILES_Y;
  localparam int unsigned ADDR_W = $clog2(DEPTH);

  logic [`NB_DATA_W-1:0] mem [DEPTH];
  logic                  rsp_valid_q;
  logic                  req_fire;

  // row-major tile address
  function automatic logic [ADDR_W-1:0] addr_of(tile_i_t i, tile_j_t j);
    return ADDR_W'(i) * ADDR_W'(`NB_TILES_X) + ADDR_W'(j);
  endfunction

  // free slot, or the held word leaves this cycle
  assign rd.ready = !rsp_valid_q || rsp_ready_i;
  assign req_fire = rd.valid && rd.ready;

  // write port for loading tiles
  always_ff @(posedge clk) begin
    if (wr_en_i) mem[addr_of(wr_i_i, wr_j_i)] <= wr_data_i;
  end

  // --------------------------------------------------
  // one-entry response register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) rsp_valid_q <= 1'b0;
    else if (req_fire) rsp_valid_q <= 1'b1;
    else if (rsp_ready_i) rsp_valid_q <= 1'b0;
  end

  // word and tag travel together
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_tag_o  <= rd.tag;
      rsp_data_o <= mem[addr_of(rd.tile_i, rd.tile_j)];
    end
  end

  assign rsp_valid_o = rsp_valid_q;

endmodule

/* logic/nb_gather.sv */
// neighborhood gather

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_gather
  import nb_fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rsp_valid_i,
  input  logic [`NB_TAG_W-1:0]   rsp_tag_i,
  input  logic [`NB_DATA_W-1:0]  rsp_data_i,
  output logic                   rsp_ready_o,
  output logic                   out_valid_o,
  output nb_data_t               out_data_o,
  output logic [`NB_GROUP_W-1:0] out_group_o,
  input  logic                   out_ready_i
);

  localparam int unsigned IDX_W = `NB_IDX_W;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`NB_COUNT - 1);

  gather_state_e          state_q;
  logic [IDX_W-1:0]       cnt_q;
  nb_data_t               data_q;
  logic [`NB_GROUP_W-1:0] group_q;
  logic [IDX_W-1:0]       tok;
  logic                   rsp_fire;
  logic                   out_fire;

  // token index sits in the low tag bits
  assign tok = rsp_tag_i[IDX_W-1:0];

  // full buffer blocks the sram, which blocks the scheduler
  assign rsp_ready_o = (state_q == GATHER_COLLECT);
  assign rsp_fire    = rsp_valid_i && rsp_ready_o;

  assign out_valid_o = (state_q == GATHER_PRESENT);
  assign out_fire    = out_valid_o && out_ready_i;

  // --------------------------------------------------
  // arrival count and state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= GATHER_COLLECT;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        GATHER_COLLECT: begin
          if (rsp_fire) begin
            // ninth arrival completes the neighborhood
            cnt_q <= (cnt_q == LAST_IDX) ? '0 : cnt_q + 1'b1;
            if (cnt_q == LAST_IDX) state_q <= GATHER_PRESENT;
          end
        end
        GATHER_PRESENT: if (out_fire) state_q <= GATHER_COLLECT;
        default: state_q <= GATHER_COLLECT;
      endcase
    end
  end

  // slot write by token, group taken from every response
  always_ff @(posedge clk) begin
    if (rsp_fire) begin
      data_q[tok] <= rsp_data_i;
      group_q     <= rsp_tag_i[`NB_TAG_W-1:IDX_W];
    end
  end

  assign out_data_o  = data_q;
  assign out_group_o = group_q;

endmodule

/* logic/nb_fetch_top.sv */
// neighborhood fetch top

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_fetch_top
  import nb_fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en_i,
  // bundle in
  input  logic                   nb_valid_i,
  output logic                   nb_ready_o,
  input  tile_i_t                center_i_i,
  input  tile_j_t                center_j_i,
  input  logic [`NB_GROUP_W-1:0] nb_group_i,
  // bundle out
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output nb_data_t               out_data_o,
  output logic [`NB_GROUP_W-1:0] out_group_o,
  // sram load port
  input  logic                   wr_en_i,
  input  tile_i_t                wr_i_i,
  input  tile_j_t                wr_j_i,
  input  logic [`NB_DATA_W-1:0]  wr_data_i,
  // status
  output logic                   busy_o,
  output logic                   done_o
);

  // --------------------------------------------------
  // internal nets
  // --------------------------------------------------
  logic [`NB_IDX_W-1:0]  idx;
  logic                  last;
  logic                  cnt_clear;
  logic                  cnt_adv;
  logic                  load;
  logic                  rsp_valid;
  logic [`NB_TAG_W-1:0]  rsp_tag;
  logic [`NB_DATA_W-1:0] rsp_data;
  logic                  rsp_ready;

  // request channel, fsm drives valid and tag, buffer the coordinates
  rd_req_if rd ();

  nb_fetch_fsm u_fsm (
    .clk, .rst, .en_i,
    .nb_valid_i, .nb_ready_o, .nb_group_i,
    .rd          (rd.sched),
    .idx_i       (idx),
    .last_i      (last),
    .cnt_clear_o (cnt_clear),
    .cnt_adv_o   (cnt_adv),
    .load_o      (load),
    .busy_o, .done_o
  );

  nb_token_counter u_cnt (
    .clk, .rst,
    .clear_i (cnt_clear),
    .adv_i   (cnt_adv),
    .idx_o   (idx),
    .last_o  (last)
  );

  nb_coord_buffer u_coord (
    .clk, .rst,
    .load_i (load),
    .center_i_i, .center_j_i,
    .idx_i  (idx),
    .rd     (rd.sched)
  );

  tile_sram u_sram (
    .clk, .rst,
    .rd          (rd.mem),
    .wr_en_i, .wr_i_i, .wr_j_i, .wr_data_i,
    .rsp_valid_o (rsp_valid),
    .rsp_tag_o   (rsp_tag),
    .rsp_data_o  (rsp_data),
    .rsp_ready_i (rsp_ready)
  );

  nb_gather u_gather (
    .clk, .rst,
    .rsp_valid_i (rsp_valid),
    .rsp_tag_i   (rsp_tag),
    .rsp_data_i  (rsp_data),
    .rsp_ready_o (rsp_ready),
    .out_valid_o, .out_data_o, .out_group_o, .out_ready_i
  );

endmodule

/* test/nb_fetch_asserts.sv */
// fetch unit assertions

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_fetch_asserts
  import nb_fetch_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic                   nb_ready_i,
  input logic                   req_valid_i,
  input logic                   req_ready_i,
  input tile_i_t                req_tile_i_i,
  input tile_j_t                req_tile_j_i,
  input logic [`NB_TAG_W-1:0]   req_tag_i,
  input logic                   out_valid_i,
  input logic                   out_ready_i,
  input nb_data_t               out_data_i,
  input logic [`NB_GROUP_W-1:0] out_group_i,
  input logic                   busy_i,
  input logic                   done_i
);

  // failures seen so far, read by the testbench
  int unsigned fail_cnt = 0;

  // --------------------------------------------------
  // handshake stability
  // --------------------------------------------------

  // stalled read request keeps valid, coordinates and tag
  req_hold_a: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_tile_i_i) &&
      $stable(req_tile_j_i) && $stable(req_tag_i))
  else begin
    fail_cnt++;
    $error("read request changed while the sram stalled it");
  end

  // presented neighborhood holds until taken
  out_hold_a: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i) &&
      $stable(out_group_i))
  else begin
    fail_cnt++;
    $error("output bundle changed before out_ready_i");
  end

  // --------------------------------------------------
  // status and reset
  // --------------------------------------------------

  // done only while busy, and a single cycle wide
  done_busy_a: assert property (@(posedge clk) disable iff (rst)
    done_i |-> busy_i ##1 !done_i)
  else begin
    fail_cnt++;
    $error("done_o high while busy_o low or longer than one cycle");
  end

  // one reset edge already taken, so state is known
  reset_quiet_a: assert property (@(posedge clk)
    rst && $past(rst) |-> !nb_ready_i && !out_valid_i && !done_i)
  else begin
    fail_cnt++;
    $error("handshake or status output high during reset");
  end

endmodule

bind nb_fetch_top nb_fetch_asserts u_asserts (
  .clk          (clk),
  .rst          (rst),
  .nb_ready_i   (nb_ready_o),
  .req_valid_i  (rd.valid),
  .req_ready_i  (rd.ready),
  .req_tile_i_i (rd.tile_i),
  .req_tile_j_i (rd.tile_j),
  .req_tag_i    (rd.tag),
  .out_valid_i  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .out_data_i   (out_data_o),
  .out_group_i  (out_group_o),
  .busy_i       (busy_o),
  .done_i       (done_o)
);

/* test/nb_fetch_tb.sv */
// neighborhood fetch testbench

`timescale 1ns/1ps

`include "nb_fetch_consts.svh"

module nb_fetch_tb
  import nb_fetch_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_ENTRIES = 12;
  localparam int NUM_WORDS   = `NB_TILES_X * `NB_TILES_Y;
  localparam int GROUP_W     = `NB_GROUP_W;
  localparam int DATA_W      = `NB_DATA_W;
  // keeps the word at tile 0,0 away from zero
  localparam int WORD_OFFSET = 7;
  // sram load and settling on top of 40 cycles per bundle
  localparam int LIMIT_CYCLES = NUM_ENTRIES * 40 + NUM_WORDS + 100;

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  // row, column and group of each center; the expected group is the one sent,
  // the expected words come from nb_word
  // entry 0 interior, 1..8 corners and edges, last entry runs the enable test
  int tab_ci [NUM_ENTRIES] = '{5, 0, 11, 0, 11, 0, 6, 11, 4, 3, 8, 7};
  int tab_cj [NUM_ENTRIES] = '{7, 0, 15, 15, 0, 8, 0, 5, 15, 3, 12, 9};
  logic [GROUP_W-1:0] tab_grp [NUM_ENTRIES] = '{12'h5a1, 12'h002, 12'hfff, 12'h010,
    12'h7c3, 12'h333, 12'h800, 12'h0ab, 12'h444, 12'h9e2, 12'h0c0, 12'h6d6};

  logic clk;
  logic rst;
  logic en;
  logic nb_valid;
  logic nb_ready;
  tile_i_t center_i;
  tile_j_t center_j;
  logic [GROUP_W-1:0] nb_group;
  logic out_valid;
  logic out_ready;
  nb_data_t out_data;
  logic [GROUP_W-1:0] out_group;
  logic wr_en;
  tile_i_t wr_i;
  tile_j_t wr_j;
  logic [DATA_W-1:0] wr_data;
  logic busy;
  logic done;

  int exp_q [$];   // table index of each accepted bundle, in order
  int sent_cnt;
  int rx_cnt;
  int done_cnt;
  logic [15:0] lfsr;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  nb_fetch_top dut_i (
    .clk, .rst, .en_i (en),
    .nb_valid_i (nb_valid), .nb_ready_o (nb_ready),
    .center_i_i (center_i), .center_j_i (center_j), .nb_group_i (nb_group),
    .out_valid_o (out_valid), .out_ready_i (out_ready),
    .out_data_o (out_data), .out_group_o (out_group),
    .wr_en_i (wr_en), .wr_i_i (wr_i), .wr_j_i (wr_j), .wr_data_i (wr_data),
    .busy_o (busy), .done_o (done)
  );

  // word stored at each tile
  function automatic int tile_word(int r, int c);
    return r * 100 + c + WORD_OFFSET;
  endfunction

  // reference neighbor of token k, offsets k/3-1 and k%3-1 clamped to the grid
  function automatic int nb_word(int ci, int cj, int k);
    int r;
    int c;
    r = ci + k / 3 - 1;
    c = cj + k % 3 - 1;
    if (r < 0) r = 0;
    if (r > `NB_TILES_Y - 1) r = `NB_TILES_Y - 1;
    if (c < 0) c = 0;
    if (c > `NB_TILES_X - 1) c = `NB_TILES_X - 1;
    return tile_word(r, c);
  endfunction

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s is %0h, expected %0h",
        $time, name, got, exp));
    end
  endtask

  // compare one output bundle with the oldest accepted entry
  task automatic check_output();
    int e;
    if (exp_q.size() == 0) begin
      report_failure("An output bundle appeared with no bundle pending");
    end else begin
      e = exp_q.pop_front();
      check_value("out_group_o", 32'(out_group), 32'(tab_grp[e]));
      for (int k = 0; k < `NB_COUNT; k++) begin
        check_value($sformatf("out_data_o[%0d]", k), 32'(out_data[k]),
          nb_word(tab_ci[e], tab_cj[e], k));
      end
      rx_cnt++;
    end
  endtask

  // offer table entry e from a rising edge, return at its transfer edge
  task automatic send_bundle(int e);
    nb_valid <= 1'b1;
    center_i <= tile_i_t'(tab_ci[e]);
    center_j <= tile_j_t'(tab_cj[e]);
    nb_group <= tab_grp[e];
    @(negedge clk);
    while (!nb_ready) @(negedge clk);
    exp_q.push_back(e);
    sent_cnt++;
    @(posedge clk);
  endtask

  // --------------------------------------------------
  // output side, sampled mid cycle
  // --------------------------------------------------
  always @(negedge clk) begin
    if (dut_i.u_asserts.fail_cnt != 0) report_failure("A bound assertion failed");
    if (!rst) begin
      if (done) done_cnt++;
      if (out_valid && out_ready) check_output();
    end
  end

  // random back-pressure, one lfsr step per bit taken
  initial begin
    lfsr = 16'd79;
    forever begin
      @(posedge clk);
      lfsr = lfsr_step(lfsr);
      out_ready <= lfsr[0];
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    report_failure("Timeout, the run did not complete in the allowed time");
  end

  initial begin
    rst = 1'b1;
    en = 1'b0;
    nb_valid = 1'b0;
    center_i = '0;
    center_j = '0;
    nb_group = '0;
    out_ready = 1'b0;
    wr_en = 1'b0;
    wr_i = '0;
    wr_j = '0;
    wr_data = '0;
    sent_cnt = 0;
    rx_cnt = 0;
    done_cnt = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // quiet after reset, nb_ready_o follows a low enable
    @(negedge clk);
    check_value("nb_ready_o", 32'(nb_ready), 32'd0);
    check_value("out_valid_o", 32'(out_valid), 32'd0);
    check_value("busy_o", 32'(busy), 32'd0);
    check_value("done_o", 32'(done), 32'd0);

    // fill the whole tile grid
    for (int r = 0; r < `NB_TILES_Y; r++) begin
      for (int c = 0; c < `NB_TILES_X; c++) begin
        @(posedge clk);
        wr_en <= 1'b1;
        wr_i <= tile_i_t'(r);
        wr_j <= tile_j_t'(c);
        wr_data <= DATA_W'(tile_word(r, c));
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;
    en <= 1'b1;
    @(negedge clk);
    check_value("nb_ready_o", 32'(nb_ready), 32'd1);

    // --------------------------------------------------
    // back to back bundles under random back-pressure
    // --------------------------------------------------
    @(posedge clk);
    for (int e = 0; e < NUM_ENTRIES - 1; e++) send_bundle(e);
    nb_valid <= 1'b0;
    wait (rx_cnt == sent_cnt);
    @(posedge clk);

    // last entry, frozen after two requests then resumed
    send_bundle(NUM_ENTRIES - 1);
    nb_valid <= 1'b0;
    repeat (2) @(posedge clk);
    en <= 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_value("nb_ready_o", 32'(nb_ready), 32'd0);
      check_value("busy_o", 32'(busy), 32'd0);
      check_value("out_valid_o", 32'(out_valid), 32'd0);
    end
    @(posedge clk);
    en <= 1'b1;
    wait (rx_cnt == sent_cnt);

    // nothing lost, nothing extra, one done pulse each
    repeat (20) begin
      @(negedge clk);
      check_value("out_valid_o", 32'(out_valid), 32'd0);
    end
    check_value("done_o pulse count", 32'(done_cnt), 32'(NUM_ENTRIES));
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/nb_fetch_pkg.sv
logic/rd_req_if.sv
logic/nb_coord_buffer.sv
logic/nb_token_counter.sv
logic/nb_fetch_fsm.sv
logic/tile_sram.sv
logic/nb_gather.sv
logic/nb_fetch_top.sv
test/nb_fetch_asserts.sv
test/nb_fetch_tb.sv

/* Makefile */
# verilator build and run for the neighborhood fetch unit

TOP := nb_fetch_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
